// ==== list.f ====
+incdir+source
source/icache_pkg.sv
source/icache_if.sv
source/icache_line_ram.sv
source/icache_way.sv
source/icache_fill_ctrl.sv
source/icache_hit_select.sv
source/icache_top.sv
tb/icache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the icache testbench with Verilator, runs it and judges the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f list.f --top-module icache_tb \
   -Mdir "$BUILD_DIR" -o icache_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/icache_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
   exit 0
fi
echo "simulation did not report success"
exit 1

// ==== source/icache_defs.svh ====
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// fetch address geometry
`define ICACHE_ADDR_BITS   32
`define ICACHE_OFFSET_BITS 6    // 64 byte lines
`define ICACHE_SET_BITS    8    // 256 sets per way
`define ICACHE_TAG_BITS    (`ICACHE_ADDR_BITS - `ICACHE_SET_BITS - `ICACHE_OFFSET_BITS)
`define ICACHE_SETS        (1 << `ICACHE_SET_BITS)

// data store shape
`define ICACHE_LINE_BITS   512
`define ICACHE_WAYS        2    // 4 works as well since the victim pointer widens with it

`endif

// ==== source/icache_fill_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "icache_defs.svh"

// splits the incoming addresses and steers fills to the victim way of their set
module icache_fill_ctrl (
   input wire logic                         clk,
   input wire logic                         rst_n,
   input wire logic                         fill_valid,
   input wire logic [`ICACHE_ADDR_BITS-1:0] fill_addr,
   input wire icache_pkg::icache_line_t     fill_line,
   input wire logic                         lookup_valid,
   input wire logic [`ICACHE_ADDR_BITS-1:0] lookup_addr,
   icache_way_req_if.ctrl                   req [`ICACHE_WAYS-1:0]
);

   localparam int WAYS     = `ICACHE_WAYS;
   localparam int SETS     = `ICACHE_SETS;
   localparam int PTR_BITS = $clog2(`ICACHE_WAYS);  // 1 bit for two ways

   icache_pkg::icache_fetch_addr_u fill_a;
   icache_pkg::icache_fetch_addr_u look_a;
   logic [PTR_BITS-1:0]            repl_q [SETS];  // round robin pointer per set
   logic [PTR_BITS-1:0]            victim;         // way that takes the current fill
   logic [PTR_BITS-1:0]            victim_nxt;

   assign fill_a.raw = fill_addr;
   assign look_a.raw = lookup_addr;

   // ==============================
   // replacement pointers
   // ==============================

   assign victim = repl_q[fill_a.f.set];

   // wrap explicitly so a way count that is not a power of two still cycles
   assign victim_nxt = (victim == PTR_BITS'(WAYS - 1)) ? '0 : victim + 1'b1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < SETS; s++) begin
            repl_q[s] <= '0;  // every set starts on way 0
         end
      end else if (fill_valid) begin
         repl_q[fill_a.f.set] <= victim_nxt;
      end
   end

   // ==============================
   // way requests
   // ==============================

   for (genvar w = 0; w < WAYS; w++) begin : g_way_req
      assign req[w].wr    = fill_valid && (victim == PTR_BITS'(w));  // victim way only
      assign req[w].wset  = fill_a.f.set;
      assign req[w].wtag  = fill_a.f.tag;
      assign req[w].wline = fill_line;
      assign req[w].rd    = lookup_valid;  // lookups probe all ways at once
      assign req[w].rset  = look_a.f.set;
      assign req[w].rtag  = look_a.f.tag;
   end

endmodule

`default_nettype wire

// ==== source/icache_hit_select.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "icache_defs.svh"

// drains the ways and registers a single hit and line response
module icache_hit_select (
   input  wire logic                     clk,
   input  wire logic                     rst_n,
   icache_way_rsp_if.sel                 rsp [`ICACHE_WAYS-1:0],
   output      logic                     rsp_valid,
   output      logic                     rsp_hit,
   output      icache_pkg::icache_line_t rsp_line
);

   localparam int WAYS = `ICACHE_WAYS;

   logic [WAYS-1:0]          vld_vec;
   logic [WAYS-1:0]          hit_vec;      // at most one bit set since tags are unique per set
   icache_pkg::icache_line_t masked [WAYS];
   icache_pkg::icache_line_t line_sel;

   for (genvar w = 0; w < WAYS; w++) begin : g_way_rsp
      assign vld_vec[w] = rsp[w].vld;
      assign hit_vec[w] = rsp[w].vld && rsp[w].hit;
      assign masked[w]  = hit_vec[w] ? rsp[w].line : '0;  // zero unless this way hit
   end

   // or of the masked lines is the one-hot mux, all zero on a miss
   always_comb begin
      line_sel = '0;
      for (int w = 0; w < WAYS; w++) begin
         line_sel = line_sel | masked[w];
      end
   end

   // ==============================
   // response register
   // ==============================

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
         rsp_hit   <= 1'b0;
      end else begin
         rsp_valid <= |vld_vec;  // all ways see the same lookup strobe
         rsp_hit   <= |hit_vec;
      end
   end

   always_ff @(posedge clk) begin
      rsp_line <= line_sel;
   end

endmodule

`default_nettype wire

// ==== source/icache_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// request side of one way, driven by the fill controller
interface icache_way_req_if;
   logic                     wr;     // fill this way at the coming edge
   icache_pkg::icache_set_t  wset;
   icache_pkg::icache_tag_t  wtag;
   icache_pkg::icache_line_t wline;
   logic                     rd;     // lookup at the coming edge, same for every way
   icache_pkg::icache_set_t  rset;
   icache_pkg::icache_tag_t  rtag;   // compared one cycle later inside the way

   modport ctrl (
      output wr, wset, wtag, wline,
      output rd, rset, rtag
   );

   modport way (
      input wr, wset, wtag, wline,
      input rd, rset, rtag
   );
endinterface

// response side of one way, read by the hit selector
interface icache_way_rsp_if;
   logic                     vld;    // a lookup was sampled one edge ago
   logic                     hit;    // only meaningful with vld
   icache_pkg::icache_line_t line;   // only meaningful with vld

   modport way (
      output vld, hit, line
   );

   modport sel (
      input vld, hit, line
   );
endinterface

`default_nettype wire

// ==== source/icache_line_ram.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "icache_defs.svh"

// simple dual port line store, one write port and one read port on one clock
module icache_line_ram (
   input  wire logic                     clk,
   input  wire logic                     wr,
   input  wire icache_pkg::icache_set_t  wset,
   input  wire icache_pkg::icache_line_t wline,
   input  wire icache_pkg::icache_set_t  rset,
   output      icache_pkg::icache_line_t rline
);

   localparam int SETS = `ICACHE_SETS;

   icache_pkg::icache_line_t mem [SETS];
   icache_pkg::icache_line_t mem_q;     // registered array read
   logic                     wr_q;      // write strobe one cycle back
   icache_pkg::icache_set_t  wset_q;
   icache_pkg::icache_line_t wline_q;
   icache_pkg::icache_set_t  rset_q;

   // the array read sees the old line when both ports hit the same set
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wset] <= wline;
      end
      mem_q <= mem[rset];
   end

   // copy of the write side so a colliding read can be patched afterwards
   always_ff @(posedge clk) begin
      wr_q    <= wr;
      wset_q  <= wset;
      wline_q <= wline;
      rset_q  <= rset;
   end

   // a same-set write in the read cycle wins over the stale array data
   assign rline = (wr_q && (wset_q == rset_q)) ? wline_q : mem_q;

endmodule

`default_nettype wire

// ==== source/icache_pkg.sv ====
`default_nettype none
`include "icache_defs.svh"

package icache_pkg;

   // ==============================
   // basic fields
   // ==============================

   typedef logic [`ICACHE_LINE_BITS-1:0]   icache_line_t;    // one full cache line
   typedef logic [`ICACHE_TAG_BITS-1:0]    icache_tag_t;     // 18 bits with the default geometry
   typedef logic [`ICACHE_SET_BITS-1:0]    icache_set_t;
   typedef logic [`ICACHE_OFFSET_BITS-1:0] icache_offset_t;  // byte within the line

   // ==============================
   // fetch address views
   // ==============================

   // msb first so the struct lines up with the raw address bits
   typedef struct packed {
      icache_tag_t    tag;
      icache_set_t    set;
      icache_offset_t offset;
   } icache_addr_fields_t;

   // the same word seen either as a plain address or split into its fields
   typedef union packed {
      logic [`ICACHE_ADDR_BITS-1:0] raw;
      icache_addr_fields_t          f;
   } icache_fetch_addr_u;

   // what each way keeps per set next to the line
   typedef struct packed {
      logic        valid;  // cleared only by reset
      icache_tag_t tag;
   } icache_tag_entry_t;

endpackage

`default_nettype wire

// ==== source/icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "icache_defs.svh"

// two way instruction cache data store, lookup to response in two edges
module icache_top (
   input  wire logic                         clk,
   input  wire logic                         rst_n,
   input  wire logic                         fill_valid,
   input  wire logic [`ICACHE_ADDR_BITS-1:0] fill_addr,
   input  wire icache_pkg::icache_line_t     fill_line,
   input  wire logic                         lookup_valid,
   input  wire logic [`ICACHE_ADDR_BITS-1:0] lookup_addr,
   output      logic                         rsp_valid,
   output      logic                         rsp_hit,
   output      icache_pkg::icache_line_t     rsp_line
);

   // one request and one response bundle per way
   icache_way_req_if req_if [`ICACHE_WAYS-1:0] ();
   icache_way_rsp_if rsp_if [`ICACHE_WAYS-1:0] ();

   // ==============================
   // feeder
   // ==============================

   icache_fill_ctrl u_fill_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .fill_valid   (fill_valid),
      .fill_addr    (fill_addr),
      .fill_line    (fill_line),
      .lookup_valid (lookup_valid),
      .lookup_addr  (lookup_addr),
      .req          (req_if)
   );

   // identical ways, the feeder picks which one gets written
   for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
      icache_way u_way (
         .clk   (clk),
         .rst_n (rst_n),
         .req   (req_if[w]),
         .rsp   (rsp_if[w])
      );
   end

   // ==============================
   // drainer
   // ==============================

   icache_hit_select u_hit_select (
      .clk       (clk),
      .rst_n     (rst_n),
      .rsp       (rsp_if),
      .rsp_valid (rsp_valid),
      .rsp_hit   (rsp_hit),
      .rsp_line  (rsp_line)
   );

endmodule

`default_nettype wire

// ==== source/icache_way.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "icache_defs.svh"

// one way of the cache, line store plus tag store plus the tag compare
module icache_way (
   input wire logic      clk,
   input wire logic      rst_n,
   icache_way_req_if.way req,
   icache_way_rsp_if.way rsp
);

   localparam int SETS = `ICACHE_SETS;

   icache_pkg::icache_tag_entry_t tag_mem [SETS];
   icache_pkg::icache_tag_entry_t tag_q;     // raw entry read at the lookup edge
   icache_pkg::icache_tag_entry_t tag_rd;    // entry after forwarding
   logic                          wr_q;      // fill strobe one cycle back
   logic                          rd_q;      // lookup strobe one cycle back
   icache_pkg::icache_set_t       wset_q;
   icache_pkg::icache_set_t       rset_q;
   icache_pkg::icache_tag_t       wtag_q;
   icache_pkg::icache_tag_t       rtag_q;    // requested tag, compared next cycle

   // ==============================
   // line store
   // ==============================

   // the RAM output goes straight out as the response line
   icache_line_ram u_line_ram (
      .clk   (clk),
      .wr    (req.wr),
      .wset  (req.wset),
      .wline (req.wline),
      .rset  (req.rset),
      .rline (rsp.line)
   );

   // ==============================
   // tag store
   // ==============================

   // only the valid bits are cleared, tags are don't care while invalid
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < SETS; s++) begin
            tag_mem[s].valid <= 1'b0;
         end
      end else if (req.wr) begin
         tag_mem[req.wset] <= '{valid: 1'b1, tag: req.wtag};  // a fill always validates
      end
   end

   always_ff @(posedge clk) begin
      tag_q  <= tag_mem[req.rset];  // old entry if the same set is filled now
      wset_q <= req.wset;
      wtag_q <= req.wtag;
      rset_q <= req.rset;
      rtag_q <= req.rtag;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_q <= 1'b0;
         rd_q <= 1'b0;
      end else begin
         wr_q <= req.wr;
         rd_q <= req.rd;
      end
   end

   // same forwarding rule as the line store so tag and line stay paired
   always_comb begin
      tag_rd = tag_q;
      if (wr_q && (wset_q == rset_q)) begin
         tag_rd = '{valid: 1'b1, tag: wtag_q};
      end
   end

   // ==============================
   // compare and response
   // ==============================

   assign rsp.vld = rd_q;
   assign rsp.hit = tag_rd.valid && (tag_rd.tag == rtag_q);

endmodule

`default_nettype wire

// ==== tb/icache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "icache_defs.svh"

module icache_tb;

   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 10;
   localparam int WAYS            = `ICACHE_WAYS;
   localparam int SETS            = `ICACHE_SETS;
   localparam int N_DIRECTED      = 60;   // cycles of the directed phases with idle gaps
   localparam int N_RANDOM        = 400;  // one lookup in every one of these cycles
   localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_DIRECTED + N_RANDOM + 100;

   // one expected response, due at a given negedge count
   typedef struct {
      int                       due;
      logic                     hit;
      icache_pkg::icache_line_t line;
   } exp_t;

   logic                         clk = 1'b0;
   logic                         rst_n;
   logic                         fill_valid;
   logic [`ICACHE_ADDR_BITS-1:0] fill_addr;
   icache_pkg::icache_line_t     fill_line;
   logic                         lookup_valid;
   logic [`ICACHE_ADDR_BITS-1:0] lookup_addr;
   logic                         rsp_valid;
   logic                         rsp_hit;
   icache_pkg::icache_line_t     rsp_line;

   logic                     ref_valid [SETS][WAYS];  // reference copy of the tag store
   icache_pkg::icache_tag_t  ref_tag   [SETS][WAYS];
   icache_pkg::icache_line_t ref_line  [SETS][WAYS];
   int                       ref_ptr   [SETS];        // next victim way per set
   exp_t                     exp_q [$];
   logic [31:0]              lfsr_state = 32'hccea_c7e7;
   int                       neg_cnt = 0;             // counts falling edges
   int                       checks  = 0;
   int                       errors  = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   icache_top uut (
      .clk          (clk),
      .rst_n        (rst_n),
      .fill_valid   (fill_valid),
      .fill_addr    (fill_addr),
      .fill_line    (fill_line),
      .lookup_valid (lookup_valid),
      .lookup_addr  (lookup_addr),
      .rsp_valid    (rsp_valid),
      .rsp_hit      (rsp_hit),
      .rsp_line     (rsp_line)
   );

   // ==============================
   // random source and helpers
   // ==============================

   // 32 bit fibonacci register with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);  // one step per bit taken
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic icache_pkg::icache_line_t random_line();
      icache_pkg::icache_line_t l;
      for (int i = 0; i < `ICACHE_LINE_BITS / 32; i++) begin
         l[i*32 +: 32] = draw_bits(32);
      end
      return l;
   endfunction

   function automatic logic [31:0] make_addr(input icache_pkg::icache_tag_t tag,
                                             input icache_pkg::icache_set_t set,
                                             input icache_pkg::icache_offset_t off);
      icache_pkg::icache_fetch_addr_u a;
      a.f.tag    = tag;
      a.f.set    = set;
      a.f.offset = off;
      return a.raw;
   endfunction

   // steps the tag until it is not resident, refills of a resident tag are never made
   function automatic icache_pkg::icache_tag_t fresh_tag(input icache_pkg::icache_set_t set,
                                                         input icache_pkg::icache_tag_t start);
      icache_pkg::icache_tag_t t;
      logic                    taken;
      t = start;
      for (int n = 0; n <= WAYS; n++) begin
         taken = 1'b0;
         for (int w = 0; w < WAYS; w++) begin
            if (ref_valid[set][w] && (ref_tag[set][w] == t)) taken = 1'b1;
         end
         if (!taken) break;
         t = t + 1'b1;
      end
      return t;
   endfunction

   // ==============================
   // reference model
   // ==============================

   function automatic void update_model(input logic [31:0] addr,
                                        input icache_pkg::icache_line_t line);
      icache_pkg::icache_fetch_addr_u a;
      int                             w;
      a.raw = addr;
      w     = ref_ptr[a.f.set];                 // round robin victim
      ref_valid[a.f.set][w] = 1'b1;
      ref_tag[a.f.set][w]   = a.f.tag;
      ref_line[a.f.set][w]  = line;
      ref_ptr[a.f.set]      = (w + 1) % WAYS;
   endfunction

   // a same edge fill is applied to the model first, which gives the forwarding rule
   function automatic logic expected_lookup(input logic [31:0] addr,
                                            output icache_pkg::icache_line_t line);
      icache_pkg::icache_fetch_addr_u a;
      logic                           hit;
      a.raw = addr;
      hit   = 1'b0;
      line  = '0;                               // a miss returns an all zero line
      for (int w = 0; w < WAYS; w++) begin
         if (ref_valid[a.f.set][w] && (ref_tag[a.f.set][w] == a.f.tag)) begin
            hit  = 1'b1;
            line = ref_line[a.f.set][w];
         end
      end
      return hit;
   endfunction

   // ==============================
   // stimulus and checking
   // ==============================

   task automatic check_value(input logic [`ICACHE_LINE_BITS-1:0] got,
                              input logic [`ICACHE_LINE_BITS-1:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   // one cycle of requests, the DUT samples them at the following edge
   task automatic drive(input logic fv, input logic [31:0] faddr,
                        input icache_pkg::icache_line_t fline,
                        input logic lv, input logic [31:0] laddr);
      exp_t                     e;
      icache_pkg::icache_line_t l;
      @(posedge clk);
      fill_valid   <= fv;
      fill_addr    <= faddr;
      fill_line    <= fline;
      lookup_valid <= lv;
      lookup_addr  <= laddr;
      if (fv) update_model(faddr, fline);
      if (lv) begin
         e.hit  = expected_lookup(laddr, l);
         e.line = l;
         e.due  = neg_cnt + 3;  // sampled one edge on, registered the edge after
         exp_q.push_back(e);
      end
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, '0, '0, 1'b0, '0);
   endtask

   // outputs are looked at on the falling edge where they are stable
   always @(negedge clk) begin : compare
      exp_t e;
      neg_cnt = neg_cnt + 1;
      if (rsp_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: response seen with no lookup pending", $time);
         end else begin
            e = exp_q.pop_front();
            check_value(neg_cnt, e.due, "response latency");
            check_value(rsp_hit, e.hit, "hit flag");
            check_value(rsp_line, e.line, "response line");
         end
      end else if ((exp_q.size() != 0) && (exp_q[0].due <= neg_cnt)) begin
         errors++;
         $display("ERROR at %0t: expected response never arrived", $time);
         void'(exp_q.pop_front());
      end
   end

   initial begin : watchdog
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin : stimulus
      icache_pkg::icache_set_t  set_a;
      icache_pkg::icache_set_t  set_b;
      icache_pkg::icache_set_t  fset;
      icache_pkg::icache_tag_t  t1;
      icache_pkg::icache_tag_t  t2;
      icache_pkg::icache_tag_t  t3;
      icache_pkg::icache_tag_t  t4;
      icache_pkg::icache_line_t line_a;
      logic                     fv;
      for (int s = 0; s < SETS; s++) begin
         ref_ptr[s] = 0;
         for (int w = 0; w < WAYS; w++) ref_valid[s][w] = 1'b0;
      end
      rst_n        <= 1'b0;
      fill_valid   <= 1'b0;
      fill_addr    <= '0;
      fill_line    <= '0;
      lookup_valid <= 1'b0;
      lookup_addr  <= '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // empty cache, every lookup misses and idle cycles give no response
      for (int i = 0; i < 8; i++) begin
         drive(1'b0, '0, '0, 1'b1, draw_bits(32));
         idle(1);
      end
      idle(3);

      // fill then look up the same line at another offset
      set_a  = icache_pkg::icache_set_t'(draw_bits(8));
      t1     = icache_pkg::icache_tag_t'(draw_bits(18));
      line_a = random_line();
      drive(1'b1, make_addr(t1, set_a, '0), line_a, 1'b0, '0);
      drive(1'b0, '0, '0, 1'b1, make_addr(t1, set_a, 6'h24));

      // two tags share a set, a third one evicts the oldest
      set_b = set_a + 1'b1;
      t1 = fresh_tag(set_b, icache_pkg::icache_tag_t'(draw_bits(18)));
      drive(1'b1, make_addr(t1, set_b, '0), random_line(), 1'b0, '0);
      t2 = fresh_tag(set_b, icache_pkg::icache_tag_t'(draw_bits(18)));
      drive(1'b1, make_addr(t2, set_b, '0), random_line(), 1'b0, '0);
      drive(1'b0, '0, '0, 1'b1, make_addr(t1, set_b, 6'h10));
      drive(1'b0, '0, '0, 1'b1, make_addr(t2, set_b, 6'h3c));
      t3 = fresh_tag(set_b, icache_pkg::icache_tag_t'(draw_bits(18)));
      drive(1'b1, make_addr(t3, set_b, '0), random_line(), 1'b0, '0);
      drive(1'b0, '0, '0, 1'b1, make_addr(t1, set_b, '0));
      drive(1'b0, '0, '0, 1'b1, make_addr(t2, set_b, '0));
      drive(1'b0, '0, '0, 1'b1, make_addr(t3, set_b, '0));

      // fill and lookup of one set at the same edge
      t4 = fresh_tag(set_b, icache_pkg::icache_tag_t'(draw_bits(18)));
      drive(1'b1, make_addr(t4, set_b, '0), random_line(), 1'b1, make_addr(t4, set_b, 6'h08));
      drive(1'b0, '0, '0, 1'b1, make_addr(t4, set_b, '0));
      idle(4);

      // a lookup every cycle over few sets and tags so hits and evictions are common
      for (int i = 0; i < N_RANDOM; i++) begin
         fset = icache_pkg::icache_set_t'(draw_bits(3));
         fv   = draw_bits(1) != 0;
         t1   = fresh_tag(fset, icache_pkg::icache_tag_t'(draw_bits(2)));
         t2   = icache_pkg::icache_tag_t'(draw_bits(2));
         set_a = icache_pkg::icache_set_t'(draw_bits(3));
         drive(fv, make_addr(t1, fset, '0), random_line(), 1'b1,
               make_addr(t2, set_a, icache_pkg::icache_offset_t'(draw_bits(6))));
      end

      // let the pipeline drain, the watchdog bounds this wait
      while (exp_q.size() != 0) idle(1);
      idle(4);

      $display("closing: %0d checks, %0d errors, %0d responses pending",
               checks, errors, exp_q.size());
      if ((errors == 0) && (checks > 0) && (exp_q.size() == 0)) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
